// ==== bcidCounter.sv ====
`timescale 1ns/1ps

module bcidCounter (
    input  logic                                ClkBx,
    input  logic                                reset_ff,
    output logic [monoPixRoPkg::BcidBits-1:0]   BcidGray
);

    import monoPixRoPkg::*;

    logic [BcidBits-1:0] binCnt;

    // Free running, wraps every 64 crossings
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            binCnt <= '0;
        end else begin
            binCnt <= binCnt + 1'b1;
        end
    end

    // One bit flips per step
    // Pixel latches sampling mid-change are off by one count at most
    assign BcidGray = binCnt ^ (binCnt >> 1);

endmodule

// ==== confShiftReg.sv ====
`timescale 1ns/1ps

module confShiftReg (
    input  logic                                ClkBx,
    input  logic                                reset_ff,
    input  logic                                DefConf,
    input  logic                                ConfShift,
    input  logic                                ConfSi,
    input  logic                                ConfLd,
    output logic                                ConfSo,
    output logic [monoPixCfgPkg::ConfBits-1:0]  Conf
);

    import monoPixCfgPkg::*;

    logic [ConfBits-1:0] shiftReg;  // Serial chain, not yet live

    // Shift path
    // New bits enter at bit 0 and walk toward the MSB
    always_ff @(posedge ClkBx) begin
        if (reset_ff || DefConf) begin
            shiftReg <= ConfDefault;
        end else if (ConfShift) begin
            shiftReg <= {shiftReg[ConfBits-2:0], ConfSi};
        end
    end

    // Load shadow holds the live configuration
    // Loading only on ConfLd keeps the lanes steady while a new word shifts in
    always_ff @(posedge ClkBx) begin
        if (reset_ff || DefConf) begin
            Conf <= ConfDefault;
        end else if (ConfLd) begin
            Conf <= shiftReg;  // Pre-edge value, even with ConfShift high
        end
    end

    // Chain output for readback, MSB first
    assign ConfSo = shiftReg[ConfBits-1];

endmodule

// ==== dataSerializer.sv ====
`timescale 1ns/1ps

module dataSerializer (
    input  logic                    ClkBx,
    input  logic                    reset_ff,
    input  logic                    Load,
    input  monoPixRoPkg::roWordU    Word,
    input  logic                    EnOut,
    output logic                    DataOut,
    output logic                    Busy
);

    import monoPixRoPkg::*;

    logic [WordBits-1:0]   shiftReg;
    logic [BitCntBits-1:0] bitCnt;  // Bits still to send

    // Control, counts down one bit per cycle
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            bitCnt <= '0;
        end else if (Load) begin
            bitCnt <= BitCntBits'(WordBits);
        end else if (bitCnt != '0) begin
            bitCnt <= bitCnt - 1'b1;
        end
    end

    // Payload, MSB sits at the top
    always_ff @(posedge ClkBx) begin
        if (Load) begin
            shiftReg <= Word.raw;
        end else if (bitCnt != '0) begin
            shiftReg <= {shiftReg[WordBits-2:0], 1'b0};
        end
    end

    assign Busy = (bitCnt != '0);

    // Line held low between words and when the lane is switched off
    assign DataOut = shiftReg[WordBits-1] & Busy & EnOut;

endmodule

// ==== hitBuffer.sv ====
`timescale 1ns/1ps

module hitBuffer (
    input  logic                                ClkBx,
    input  logic                                reset_ff,
    input  logic [monoPixCfgPkg::NumCols-1:0]   HitIn,
    input  logic                                Pulse,
    input  logic [monoPixCfgPkg::NumCols-1:0]   ColPulseSel,
    input  logic                                EnFlavor,
    input  logic                                EnHitOr,
    input  logic                                Freeze,
    input  logic [monoPixRoPkg::BcidBits-1:0]   BcidGray,
    input  logic                                Pop,
    output logic                                AnyPending,
    output monoPixRoPkg::roWordU                HitWord,
    output logic                                HitOr
);

    import monoPixCfgPkg::*;
    import monoPixRoPkg::*;

    logic [NumCols-1:0]  effHit;   // Sensor hit or injected pulse
    logic [NumCols-1:0]  capture;
    logic [NumCols-1:0]  popMask;
    logic [NumCols-1:0]  pending;
    logic [BcidBits-1:0] stamp [NumCols];
    logic [ColBits-1:0]  lowCol;   // Lowest pending column

    assign effHit = HitIn | ({NumCols{Pulse}} & ColPulseSel);

    // Only an empty latch takes a new hit
    assign capture = effHit & ~pending & {NumCols{EnFlavor & ~Freeze}};

    // Priority encoder, column 0 wins
    always_comb begin
        lowCol = '0;
        for (int c = NumCols - 1; c >= 0; c--) begin
            if (pending[c]) begin
                lowCol = ColBits'(c);
            end
        end
    end

    assign popMask = Pop ? (NumCols'(1) << lowCol) : '0;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            pending <= '0;
        end else begin
            pending <= (pending | capture) & ~popMask;
        end
    end

    // BCID stamp, written once per capture
    always_ff @(posedge ClkBx) begin
        for (int c = 0; c < NumCols; c++) begin
            if (capture[c]) begin
                stamp[c] <= BcidGray;  // Count of the cycle before the edge
            end
        end
    end

    assign AnyPending = |pending;

    always_comb begin
        HitWord.hit.col  = lowCol;
        HitWord.hit.bcid = stamp[lowCol];
    end

    // Fast trigger output, bypasses the latches
    assign HitOr = (|effHit) & EnHitOr;

endmodule

// ==== monoPixCfgPkg.sv ====
package monoPixCfgPkg;

    // Array sizes of the periphery
    localparam int NumFlavors = 4;  // PMOS_NOSF, PMOS, COMP, HV
    localparam int NumCols    = 8;  // Columns per flavor

    // Total configuration length in bits
    localparam int ConfBits = 48;

    // Field offsets into the configuration word
    // Bit 0 is the last bit shifted in
    localparam int EnOutLsb         = 0;   // Output enable, one bit per flavor
    localparam int EnFlavorLsb      = 4;   // Hit capture enable
    localparam int EnTestPatternLsb = 8;   // Fixed word instead of hit data
    localparam int EnHitOrLsb       = 12;  // HitOr output enable
    localparam int ColPulseSelLsb   = 16;  // Injection select, flavor-major

    // Outputs on, test pattern on, capture and injection off
    localparam logic [ConfBits-1:0] ConfDefault =
        (ConfBits'({NumFlavors{1'b1}}) << EnOutLsb) |
        (ConfBits'({NumFlavors{1'b1}}) << EnTestPatternLsb);

endpackage

// ==== monoPixCore.sv ====
`timescale 1ns/1ps

module monoPixCore (
    input  logic                                                    ClkBx,
    input  logic                                                    reset_ff,
    input  logic                                                    DefConf,
    input  logic                                                    ConfShift,
    input  logic                                                    ConfSi,
    input  logic                                                    ConfLd,
    input  logic                                                    Pulse,
    input  logic [monoPixCfgPkg::NumFlavors*monoPixCfgPkg::NumCols-1:0] HitIn,
    input  logic [monoPixCfgPkg::NumFlavors-1:0]                    Read,
    input  logic [monoPixCfgPkg::NumFlavors-1:0]                    Freeze,
    output logic                                                    ConfSo,
    output logic [monoPixCfgPkg::NumFlavors-1:0]                    TokenOut,
    output logic [monoPixCfgPkg::NumFlavors-1:0]                    DataOut,
    output logic [monoPixCfgPkg::NumFlavors-1:0]                    HitOr
);

    import monoPixCfgPkg::*;
    import monoPixRoPkg::*;

    logic [ConfBits-1:0] conf;      // Live configuration
    logic [BcidBits-1:0] bcidGray;  // Shared by all lanes

    confShiftReg confReg (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .DefConf   (DefConf),
        .ConfShift (ConfShift),
        .ConfSi    (ConfSi),
        .ConfLd    (ConfLd),
        .ConfSo    (ConfSo),
        .Conf      (conf)
    );

    bcidCounter bcidCnt (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .BcidGray (bcidGray)
    );

    // One readout lane per flavor
    for (genvar f = 0; f < NumFlavors; f++) begin : lane
        logic   anyPending;
        logic   pop;
        logic   load;
        logic   busy;
        roWordU hitWord;
        roWordU word;

        hitBuffer hitBuf (
            .ClkBx       (ClkBx),
            .reset_ff    (reset_ff),
            .HitIn       (HitIn[f*NumCols +: NumCols]),
            .Pulse       (Pulse),
            .ColPulseSel (conf[ColPulseSelLsb + f*NumCols +: NumCols]),
            .EnFlavor    (conf[EnFlavorLsb + f]),
            .EnHitOr     (conf[EnHitOrLsb + f]),
            .Freeze      (Freeze[f]),
            .BcidGray    (bcidGray),
            .Pop         (pop),
            .AnyPending  (anyPending),
            .HitWord     (hitWord),
            .HitOr       (HitOr[f])
        );

        readoutCtrl roCtrl (
            .ClkBx         (ClkBx),
            .reset_ff      (reset_ff),
            .Read          (Read[f]),
            .AnyPending    (anyPending),
            .Busy          (busy),
            .EnOut         (conf[EnOutLsb + f]),
            .EnTestPattern (conf[EnTestPatternLsb + f]),
            .HitWord       (hitWord),
            .TokenOut      (TokenOut[f]),
            .Pop           (pop),
            .Load          (load),
            .Word          (word)
        );

        dataSerializer ser (
            .ClkBx    (ClkBx),
            .reset_ff (reset_ff),
            .Load     (load),
            .Word     (word),
            .EnOut    (conf[EnOutLsb + f]),
            .DataOut  (DataOut[f]),
            .Busy     (busy)
        );
    end

endmodule

// ==== monoPixRoPkg.sv ====
package monoPixRoPkg;

    localparam int BcidBits = 6;  // Bunch-crossing stamp width
    localparam int ColBits  = 3;  // Column index within a flavor
    localparam int WordBits = 9;  // One serialized readout word

    // Serializer bit counter, must hold WordBits
    localparam int BitCntBits = $clog2(WordBits + 1);

    // Known word for link checks without hits
    localparam logic [WordBits-1:0] TestPattern = 9'h1A5;

    // Readout word
    // Hit view is column over Gray BCID, raw view is what goes on the wire
    typedef union packed {
        struct packed {
            logic [ColBits-1:0]  col;   // Upper bits
            logic [BcidBits-1:0] bcid;  // Gray coded stamp
        } hit;
        logic [WordBits-1:0] raw;
    } roWordU;

endpackage

// ==== readoutCtrl.sv ====
`timescale 1ns/1ps

module readoutCtrl (
    input  logic                    ClkBx,
    input  logic                    reset_ff,
    input  logic                    Read,
    input  logic                    AnyPending,
    input  logic                    Busy,
    input  logic                    EnOut,
    input  logic                    EnTestPattern,
    input  monoPixRoPkg::roWordU    HitWord,
    output logic                    TokenOut,
    output logic                    Pop,
    output logic                    Load,
    output monoPixRoPkg::roWordU    Word
);

    import monoPixRoPkg::*;

    logic readReg;  // Read after the input flop
    logic accept;

    // Read arrives from off chip
    // One flop before it touches the token logic
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            readReg <= 1'b0;
        end else begin
            readReg <= Read;
        end
    end

    // Token offered only when a word is ready and the line is free
    // Busy from the serializer holds it low until the last bit is out
    assign TokenOut = EnOut & AnyPending & ~Busy;

    // Read without a token is dropped
    assign accept = readReg & TokenOut;

    // Pop and Load fire on the same edge
    // The word below is taken before the column clears
    assign Pop  = accept;
    assign Load = accept;

    // Word source
    always_comb begin
        if (EnTestPattern) begin
            Word.raw = TestPattern;  // Fixed word, column data ignored
        end else begin
            Word.raw = HitWord.raw;
        end
    end

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
rm -rf obj_dir sim.log
{ verilator --binary --assert --top-module tbMonoPix -f vlog.f && \
    ./obj_dir/VtbMonoPix || echo "TEST FAILED"; } 2>&1 | tee sim.log
grep -q "TEST FAILED" sim.log && echo "Simulation failed" && exit 1 || \
    echo "Simulation passed"

// ==== tbMonoPix.sv ====
`timescale 1ns/1ps

module tbMonoPix;

    import monoPixCfgPkg::*;
    import monoPixRoPkg::*;

    localparam logic [ConfBits-1:0] ExpDefault = 48'h0000_0000_0F0F;  // EnOut and test pattern on
    localparam logic [WordBits-1:0] ExpPattern = 9'h1A5;
    localparam int MaxCycles = 3000;  // Tests take about 1500 cycles, twice that as margin

    logic ClkBx = 1'b0;
    logic reset_ff;
    logic DefConf;
    logic ConfShift;
    logic ConfSi;
    logic ConfLd;
    logic Pulse;
    logic [NumFlavors*NumCols-1:0] HitIn;
    logic [NumFlavors-1:0] Read;
    logic [NumFlavors-1:0] Freeze;
    logic ConfSo;
    logic [NumFlavors-1:0] TokenOut;
    logic [NumFlavors-1:0] DataOut;
    logic [NumFlavors-1:0] HitOr;

    int errCount = 0;
    int wordCount = 0;
    int cycleCnt = 0;

    // Reference model state
    logic [ConfBits-1:0] mShift;
    logic [ConfBits-1:0] mConf;
    logic [BcidBits-1:0] mBin;
    logic [NumCols-1:0]  mPend [NumFlavors];
    logic [BcidBits-1:0] mStamp [NumFlavors][NumCols];  // Gray stamps
    logic [NumFlavors-1:0] mReadReg;
    logic [WordBits-1:0] txWord [NumFlavors];
    int                  txLeft [NumFlavors];    // Bits still on the line
    logic [WordBits-1:0] lastWord [NumFlavors];  // Word of the latest accepted Read

    logic [NumCols-1:0]    effHit [NumFlavors];
    logic [NumFlavors-1:0] expToken;
    logic [NumFlavors-1:0] expData;
    logic [NumFlavors-1:0] expHitOr;

    monoPixCore dut (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .DefConf   (DefConf),
        .ConfShift (ConfShift),
        .ConfSi    (ConfSi),
        .ConfLd    (ConfLd),
        .Pulse     (Pulse),
        .HitIn     (HitIn),
        .Read      (Read),
        .Freeze    (Freeze),
        .ConfSo    (ConfSo),
        .TokenOut  (TokenOut),
        .DataOut   (DataOut),
        .HitOr     (HitOr)
    );

    always #10 ClkBx = ~ClkBx;

    // Each Gray bit is the XOR of two neighbouring binary bits
    function automatic logic [BcidBits-1:0] toGray(input logic [BcidBits-1:0] b);
        logic [BcidBits-1:0] g;
        g[BcidBits-1] = b[BcidBits-1];
        for (int i = BcidBits - 2; i >= 0; i--) begin
            g[i] = b[i+1] ^ b[i];
        end
        return g;
    endfunction

    // Config word from its fields, EnOut in the lowest bits
    function automatic logic [ConfBits-1:0] makeConf(
        input logic [NumFlavors-1:0]         enOut,
        input logic [NumFlavors-1:0]         enFlavor,
        input logic [NumFlavors-1:0]         enTp,
        input logic [NumFlavors-1:0]         enHitOr,
        input logic [NumFlavors*NumCols-1:0] colSel
    );
        return {colSel, enHitOr, enTp, enFlavor, enOut};
    endfunction

    always_comb begin
        for (int f = 0; f < NumFlavors; f++) begin
            effHit[f] = HitIn[f*NumCols +: NumCols];
            if (Pulse) begin
                effHit[f] = effHit[f] | mConf[ColPulseSelLsb + f*NumCols +: NumCols];
            end
            expHitOr[f] = (|effHit[f]) & mConf[EnHitOrLsb + f];
            expToken[f] = mConf[EnOutLsb + f] & (|mPend[f]) & (txLeft[f] == 0);
            expData[f]  = (txLeft[f] > 0) ? (mConf[EnOutLsb + f] & txWord[f][txLeft[f] - 1])
                                          : 1'b0;
        end
    end

    always @(posedge ClkBx) begin
        logic [NumCols-1:0]  cap;
        logic [NumCols-1:0]  newPend;
        logic [WordBits-1:0] word;
        logic                accept;
        int                  low;
        if (reset_ff || DefConf) begin
            mShift <= ExpDefault;
            mConf  <= ExpDefault;
        end else begin
            if (ConfShift) begin
                mShift <= {mShift[ConfBits-2:0], ConfSi};
            end
            if (ConfLd) begin
                mConf <= mShift;
            end
        end
        mBin <= reset_ff ? '0 : mBin + 1'b1;
        for (int f = 0; f < NumFlavors; f++) begin
            cap = (mConf[EnFlavorLsb + f] && !Freeze[f]) ? (effHit[f] & ~mPend[f]) : '0;
            low = -1;
            for (int c = NumCols - 1; c >= 0; c--) begin
                if (mPend[f][c]) begin
                    low = c;
                end
            end
            for (int c = 0; c < NumCols; c++) begin
                if (cap[c]) begin
                    mStamp[f][c] <= toGray(mBin);  // Count before this edge
                end
            end
            accept  = mReadReg[f] & expToken[f];
            newPend = mPend[f] | cap;
            if (reset_ff) begin
                mPend[f]    <= '0;
                txLeft[f]   <= 0;
                mReadReg[f] <= 1'b0;
            end else begin
                mReadReg[f] <= Read[f];
                if (accept) begin
                    word = mConf[EnTestPatternLsb + f] ? ExpPattern
                                                       : {ColBits'(low), mStamp[f][low]};
                    newPend[low] = 1'b0;
                    txWord[f]   <= word;
                    lastWord[f] <= word;
                    txLeft[f]   <= WordBits;
                end else if (txLeft[f] > 0) begin
                    txLeft[f] <= txLeft[f] - 1;
                end
                mPend[f] <= newPend;
            end
        end
    end

    task automatic reportMismatch(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        errCount++;
    endtask

    assert property (@(posedge ClkBx) disable iff (reset_ff) ConfSo == mShift[ConfBits-1])
        else reportMismatch("ConfSo differs from the model chain");
    assert property (@(posedge ClkBx) disable iff (reset_ff) TokenOut == expToken)
        else reportMismatch($sformatf("TokenOut %b, expected %b", TokenOut, expToken));
    assert property (@(posedge ClkBx) disable iff (reset_ff) DataOut == expData)
        else reportMismatch($sformatf("DataOut %b, expected %b", DataOut, expData));
    assert property (@(posedge ClkBx) disable iff (reset_ff) HitOr == expHitOr)
        else reportMismatch($sformatf("HitOr %b, expected %b", HitOr, expHitOr));

    // Run limit
    always @(posedge ClkBx) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= MaxCycles) begin
            $display("Timeout: run stopped after %0d cycles", cycleCnt);
            $display("Errors: %0d, words read: %0d", errCount, wordCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic stepCycle();
        @(posedge ClkBx);
        #2;
    endtask

    // MSB first, so bit 0 ends up last
    task automatic shiftConf(input logic [ConfBits-1:0] w);
        for (int i = ConfBits - 1; i >= 0; i--) begin
            ConfShift = 1'b1;
            ConfSi    = w[i];
            stepCycle();
        end
        ConfShift = 1'b0;
    endtask

    // Shadow takes the chain on one edge
    task automatic loadConf();
        ConfLd = 1'b1;
        stepCycle();
        ConfLd = 1'b0;
    endtask

    task automatic shiftWordIn(input logic [ConfBits-1:0] w);
        shiftConf(w);
        loadConf();
    endtask

    // Ring shift, chain contents restored at the end
    task automatic readBackConf(input logic [ConfBits-1:0] expWord);
        logic [ConfBits-1:0] got;
        for (int i = ConfBits - 1; i >= 0; i--) begin
            got[i]    = ConfSo;
            ConfSi    = ConfSo;
            ConfShift = 1'b1;
            stepCycle();
        end
        ConfShift = 1'b0;
        assert (got == expWord)
            else reportMismatch($sformatf("config readback %h, expected %h", got, expWord));
    endtask

    task automatic pulseHits(input logic [NumFlavors*NumCols-1:0] hits);
        HitIn = hits;
        stepCycle();
        HitIn = '0;
    endtask

    task automatic waitToken(input int f);
        int n;
        n = 0;
        while (!TokenOut[f] && n < 20) begin
            stepCycle();
            n++;
        end
        assert (TokenOut[f]) else begin
            $display("Token of flavor %0d did not rise within 20 cycles at %0d ns", f, $time);
            errCount++;
        end
    endtask

    // One Read, E is the edge after the registered sample
    task automatic readWord(input int f);
        logic [WordBits-1:0] rx;
        Read[f] = 1'b1;
        stepCycle();
        Read[f] = 1'b0;
        @(posedge ClkBx);
        for (int b = WordBits - 1; b >= 0; b--) begin
            @(negedge ClkBx);
            rx[b] = DataOut[f];
        end
        stepCycle();
        wordCount++;
        assert (rx == lastWord[f])
            else reportMismatch($sformatf("flavor %0d word %h, expected %h", f, rx, lastWord[f]));
    endtask

    task automatic drainFlavor(input int f, input int expN);
        int n;
        n = 0;
        if (expN > 0) begin
            waitToken(f);
        end
        while (TokenOut[f] && n <= NumCols) begin
            readWord(f);
            n++;
        end
        assert (n == expN)
            else reportMismatch($sformatf("flavor %0d gave %0d words, expected %0d", f, n, expN));
    endtask

    initial begin
        logic [ConfBits-1:0]         rnd;
        logic [NumFlavors*NumCols-1:0] hits;
        logic [NumCols-1:0]          cols;
        void'($urandom(58));
        reset_ff  = 1'b1;
        DefConf   = 1'b0;
        ConfShift = 1'b0;
        ConfSi    = 1'b0;
        ConfLd    = 1'b0;
        Pulse     = 1'b0;
        HitIn     = '0;
        Read      = '0;
        Freeze    = '0;
        repeat (2) @(posedge ClkBx);
        #2;
        reset_ff = 1'b0;

        // Default config, capture off
        readBackConf(ExpDefault);
        for (int f = 0; f < NumFlavors; f++) begin
            pulseHits({$urandom()});
            stepCycle();
            assert (TokenOut == '0) else reportMismatch("TokenOut rose with capture off");
        end

        // Random load and readback, then default restore
        rnd = {16'($urandom()), $urandom()};
        shiftWordIn(rnd);
        readBackConf(rnd);
        DefConf = 1'b1;
        stepCycle();
        DefConf = 1'b0;
        readBackConf(ExpDefault);

        // Hit readout with BCID stamps
        shiftWordIn(makeConf('1, '1, '0, '1, '0));
        for (int r = 0; r < 3; r++) begin
            hits = $urandom();
            pulseHits(hits);
            repeat ($urandom_range(5, 0)) stepCycle();
            for (int f = 0; f < NumFlavors; f++) begin
                drainFlavor(f, $countones(hits[f*NumCols +: NumCols]));
            end
        end

        // Freeze on flavor 1
        Freeze = 4'b0010;
        stepCycle();
        repeat (3) pulseHits({16'h0, 8'($urandom_range(255, 1)), 8'h0});
        stepCycle();
        assert (TokenOut[1] == 1'b0) else reportMismatch("frozen hits raised TokenOut");
        Freeze = '0;
        stepCycle();
        pulseHits(32'h0000_2000);  // Column 5 of flavor 1
        drainFlavor(1, 1);

        // Injection, HitOr only on flavors 0 and 2
        hits = $urandom();
        shiftWordIn(makeConf('1, '1, '0, 4'b0101, hits));
        Pulse = 1'b1;
        stepCycle();
        Pulse = 1'b0;
        for (int f = 0; f < NumFlavors; f++) begin
            drainFlavor(f, $countones(hits[f*NumCols +: NumCols]));
        end

        // Test pattern on every lane
        shiftWordIn(makeConf('1, '1, '1, '0, '0));
        hits = $urandom();
        pulseHits(hits);
        for (int f = 0; f < NumFlavors; f++) begin
            drainFlavor(f, $countones(hits[f*NumCols +: NumCols]));
        end

        // Flavor 2 output off in the middle of a word, then Read must be ignored
        cols = {1'b1, 7'($urandom_range(127, 1))};
        pulseHits({8'h0, cols, 16'h0});
        shiftConf(makeConf(4'b1011, '1, '0, '0, '0));
        Read[2] = 1'b1;
        stepCycle();
        Read[2] = 1'b0;
        repeat (4) stepCycle();
        loadConf();  // Test pattern still on the line
        repeat (12) stepCycle();
        Read[2] = 1'b1;
        stepCycle();
        Read[2] = 1'b0;
        repeat (12) stepCycle();
        assert (TokenOut[2] == 1'b0) else reportMismatch("TokenOut rose with output off");
        shiftWordIn(makeConf('1, '1, '0, '0, '0));
        drainFlavor(2, $countones(cols) - 1);

        $display("Errors: %0d, words read: %0d, cycles: %0d", errCount, wordCount, cycleCnt);
        if (errCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
monoPixCfgPkg.sv
monoPixRoPkg.sv
confShiftReg.sv
bcidCounter.sv
hitBuffer.sv
dataSerializer.sv
readoutCtrl.sv
monoPixCore.sv
tbMonoPix.sv
